//--- common/box_pkg.sv
`default_nettype none

package box_pkg;

  // Frame geometry.
  localparam int COLS = 16;
  localparam int ROWS = 8;
  localparam int COL_W = $clog2(COLS);
  localparam int ROW_W = $clog2(ROWS);

  localparam int PIX_W = 8;

  // One 3x3 sum needs 9 * 255 = 2295, which fits in 12 bits.
  localparam int WIN_SUM_W = 12;

  // Running total over the last RUN_LEN window sums of a row.
  localparam int RUN_LEN = 8;
  localparam int RUN_SUM_W = 15;
  localparam int REGION = 9 * RUN_LEN;

  // Cycles from a window strobe to a valid window sum.
  localparam int SUM_LAT = 5;

  // Pixel strobe to o_bin_valid: control, sum, accumulator, threshold.
  localparam int OUT_LAT = SUM_LAT + 3;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FILL,
    ST_RUN,
    ST_DRAIN
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- line_buffer/line_buffer.sv
`default_nettype none

module line_buffer
  import box_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic [PIX_W-1:0] i_pixel,
  input  logic             i_pixel_valid,
  input  logic             i_frame_start,
  output logic [PIX_W-1:0] o_col_top,
  output logic [PIX_W-1:0] o_col_mid,
  output logic [PIX_W-1:0] o_col_bot,
  output logic             o_col_valid
);

  // Row memory 0 holds the row two above, row memory 1 the row just above.
  logic [PIX_W-1:0] row_mem0 [COLS];
  logic [PIX_W-1:0] row_mem1 [COLS];

  logic [COL_W-1:0] ptr;
  logic [COL_W-1:0] col_idx;

  // The frame start pixel always lands in column 0.
  assign col_idx = i_frame_start ? '0 : ptr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr         <= '0;
      o_col_valid <= 1'b0;
    end else begin
      o_col_valid <= i_pixel_valid;
      if (i_pixel_valid) begin
        ptr <= (col_idx == COLS - 1) ? '0 : col_idx + 1'b1;
      end
    end
  end

  // Read both rows, then push the column up by one row.
  always_ff @(posedge clk) begin
    if (i_pixel_valid) begin
      o_col_top         <= row_mem0[col_idx];
      o_col_mid         <= row_mem1[col_idx];
      o_col_bot         <= i_pixel;
      row_mem0[col_idx] <= row_mem1[col_idx];
      row_mem1[col_idx] <= i_pixel;
    end
  end

  // Whole frames leave the pointer back at column 0.
  frame_starts_at_col0: assert property (
    @(posedge clk) disable iff (!rst_n)
    i_pixel_valid && i_frame_start |-> ptr == '0
  ) else $error("line_buffer column pointer not at column 0 at frame start");

endmodule

`default_nettype wire

//--- line_buffer/window_regs.sv
`default_nettype none

module window_regs
  import box_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic [PIX_W-1:0] i_col_top,
  input  logic [PIX_W-1:0] i_col_mid,
  input  logic [PIX_W-1:0] i_col_bot,
  input  logic             i_col_valid,
  output logic [PIX_W-1:0] o_tap0,
  output logic [PIX_W-1:0] o_tap1,
  output logic [PIX_W-1:0] o_tap2,
  output logic [PIX_W-1:0] o_tap3,
  output logic [PIX_W-1:0] o_tap4,
  output logic [PIX_W-1:0] o_tap5,
  output logic [PIX_W-1:0] o_tap6,
  output logic [PIX_W-1:0] o_tap7,
  output logic [PIX_W-1:0] o_tap8
);

  logic [PIX_W-1:0] old_top, old_mid, old_bot;
  logic [PIX_W-1:0] prv_top, prv_mid, prv_bot;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      old_top <= '0;
      old_mid <= '0;
      old_bot <= '0;
      prv_top <= '0;
      prv_mid <= '0;
      prv_bot <= '0;
    end else if (i_col_valid) begin
      old_top <= prv_top;
      old_mid <= prv_mid;
      old_bot <= prv_bot;
      prv_top <= i_col_top;
      prv_mid <= i_col_mid;
      prv_bot <= i_col_bot;
    end
  end

  // Newest column is taken from the line buffer output registers.
  assign o_tap0 = old_top;
  assign o_tap1 = prv_top;
  assign o_tap2 = i_col_top;
  assign o_tap3 = old_mid;
  assign o_tap4 = prv_mid;
  assign o_tap5 = i_col_mid;
  assign o_tap6 = old_bot;
  assign o_tap7 = prv_bot;
  assign o_tap8 = i_col_bot;

endmodule

`default_nettype wire

//--- window_sum/window_sum.sv
`default_nettype none

module window_sum
  import box_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [PIX_W-1:0]     i_tap0,
  input  logic [PIX_W-1:0]     i_tap1,
  input  logic [PIX_W-1:0]     i_tap2,
  input  logic [PIX_W-1:0]     i_tap3,
  input  logic [PIX_W-1:0]     i_tap4,
  input  logic [PIX_W-1:0]     i_tap5,
  input  logic [PIX_W-1:0]     i_tap6,
  input  logic [PIX_W-1:0]     i_tap7,
  input  logic [PIX_W-1:0]     i_tap8,
  input  logic                 i_win_valid,
  input  logic                 i_row_first,
  output logic [RUN_SUM_W-1:0] o_run_sum,
  output logic [PIX_W-1:0]     o_centre,
  output logic                 o_run_valid
);

  logic [PIX_W-1:0]     tap_q [9];
  logic [PIX_W:0]       lvl1 [4];
  logic [PIX_W+1:0]     lvl2 [2];
  logic [PIX_W+2:0]     lvl3;
  logic [WIN_SUM_W-1:0] win_sum;
  logic [PIX_W-1:0]     tap8_d [3];
  logic [PIX_W-1:0]     cen_d [4];
  logic [SUM_LAT-1:0]   vld;
  logic [SUM_LAT-1:0]   rfirst;
  logic [WIN_SUM_W-1:0] hist [RUN_LEN];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld         <= '0;
      o_run_valid <= 1'b0;
    end else begin
      vld         <= {vld[SUM_LAT-2:0], i_win_valid};
      o_run_valid <= vld[SUM_LAT-1];
    end
  end

  // Five stage sum: taps, pairs, quads, eight, then the ninth tap.
  always_ff @(posedge clk) begin
    rfirst   <= {rfirst[SUM_LAT-2:0], i_row_first};
    tap_q[0] <= i_tap0;
    tap_q[1] <= i_tap1;
    tap_q[2] <= i_tap2;
    tap_q[3] <= i_tap3;
    tap_q[4] <= i_tap4;
    tap_q[5] <= i_tap5;
    tap_q[6] <= i_tap6;
    tap_q[7] <= i_tap7;
    tap_q[8] <= i_tap8;
    for (int i = 0; i < 4; i++) begin
      lvl1[i] <= tap_q[2*i] + tap_q[2*i+1];
    end
    lvl2[0]   <= lvl1[0] + lvl1[1];
    lvl2[1]   <= lvl1[2] + lvl1[3];
    lvl3      <= lvl2[0] + lvl2[1];
    win_sum   <= lvl3 + tap8_d[2];
    tap8_d[0] <= tap_q[8];
    tap8_d[1] <= tap8_d[0];
    tap8_d[2] <= tap8_d[1];
    cen_d[0]  <= tap_q[4];
    cen_d[1]  <= cen_d[0];
    cen_d[2]  <= cen_d[1];
    cen_d[3]  <= cen_d[2];
  end

  // Running row total. The delay line only moves on a valid sum.
  // At row start the first sum is replicated over the whole run.
  always_ff @(posedge clk) begin
    if (vld[SUM_LAT-1]) begin
      o_centre <= cen_d[3];
      if (rfirst[SUM_LAT-1]) begin
        o_run_sum <= RUN_SUM_W'(RUN_LEN * win_sum);
        for (int i = 0; i < RUN_LEN; i++) begin
          hist[i] <= win_sum;
        end
      end else begin
        o_run_sum <= o_run_sum + RUN_SUM_W'(win_sum) - RUN_SUM_W'(hist[RUN_LEN-1]);
        hist[0]   <= win_sum;
        for (int i = 1; i < RUN_LEN; i++) begin
          hist[i] <= hist[i-1];
        end
      end
    end
  end

  quiet_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> !o_run_valid [*SUM_LAT]
  ) else $error("window_sum run_valid raised too early after reset");

endmodule

`default_nettype wire

//--- verilog/filter_ctrl.sv
`default_nettype none

module filter_ctrl
  import box_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic i_pixel_valid,
  input  logic i_frame_start,
  output logic o_win_valid,
  output logic o_row_first,
  output logic o_frame_done
);

  ctrl_state_e      state;
  logic [COL_W-1:0] col_cnt;
  logic [COL_W-1:0] cur_col;
  logic [ROW_W-1:0] row_cnt;
  logic [ROW_W-1:0] cur_row;
  logic [3:0]       drain_left;
  logic             accept;
  logic             win_hit;
  logic             last_pix;

  assign accept   = i_pixel_valid &&
                    (i_frame_start || state == ST_FILL || state == ST_RUN);
  assign cur_col  = i_frame_start ? '0 : col_cnt;
  assign cur_row  = i_frame_start ? '0 : row_cnt;
  assign win_hit  = accept && cur_row >= 2 && cur_col >= 2;
  assign last_pix = accept && cur_row == ROWS - 1 && cur_col == COLS - 1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= ST_IDLE;
      col_cnt      <= '0;
      row_cnt      <= '0;
      drain_left   <= '0;
      o_win_valid  <= 1'b0;
      o_row_first  <= 1'b0;
      o_frame_done <= 1'b0;
    end else begin
      o_win_valid  <= win_hit;
      o_row_first  <= win_hit && cur_col == 2;
      o_frame_done <= (drain_left == 1);

      // Counts the pipeline out after the last pixel of a frame.
      if (last_pix) begin
        drain_left <= 4'(OUT_LAT);
      end else if (drain_left != 0) begin
        drain_left <= drain_left - 1'b1;
      end

      if (accept) begin
        col_cnt <= (cur_col == COLS - 1) ? '0 : cur_col + 1'b1;
        if (cur_col == COLS - 1) begin
          row_cnt <= (cur_row == ROWS - 1) ? '0 : cur_row + 1'b1;
        end
      end

      if (accept && i_frame_start) begin
        state <= ST_FILL;
      end else begin
        case (state)
          ST_FILL:  if (win_hit) state <= ST_RUN;
          ST_RUN:   if (last_pix) state <= ST_DRAIN;
          ST_DRAIN: if (drain_left == 1) state <= ST_IDLE;
          default:  state <= ST_IDLE;
        endcase
      end
    end
  end

  no_window_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    state == ST_IDLE |-> !o_win_valid
  ) else $error("filter_ctrl window strobe while idle");

endmodule

`default_nettype wire

//--- verilog/threshold_unit.sv
`default_nettype none

module threshold_unit
  import box_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [RUN_SUM_W-1:0] i_run_sum,
  input  logic [PIX_W-1:0]     i_centre,
  input  logic                 i_run_valid,
  output logic                 o_bin,
  output logic                 o_bin_valid
);

  logic [RUN_SUM_W-1:0] scaled;

  // Centre scaled to the pixel count of a full run, 255 * 72 fits.
  assign scaled = RUN_SUM_W'(i_centre) * RUN_SUM_W'(REGION);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_bin_valid <= 1'b0;
    end else begin
      o_bin_valid <= i_run_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_run_valid) begin
      o_bin <= (scaled > i_run_sum);
    end
  end

endmodule

`default_nettype wire

//--- verilog/box_threshold_top.sv
`default_nettype none

module box_threshold_top
  import box_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic [PIX_W-1:0] i_pixel,
  input  logic             i_pixel_valid,
  input  logic             i_frame_start,
  output logic             o_bin,
  output logic             o_bin_valid,
  output logic             o_frame_done
);

  logic [PIX_W-1:0]     col_top, col_mid, col_bot;
  logic                 col_valid;
  logic [PIX_W-1:0]     tap0, tap1, tap2, tap3, tap4, tap5, tap6, tap7, tap8;
  logic                 win_valid;
  logic                 row_first;
  logic [RUN_SUM_W-1:0] run_sum;
  logic [PIX_W-1:0]     centre;
  logic                 run_valid;

  line_buffer u_line_buffer (
    .clk(clk), .rst_n(rst_n),
    .i_pixel(i_pixel), .i_pixel_valid(i_pixel_valid), .i_frame_start(i_frame_start),
    .o_col_top(col_top), .o_col_mid(col_mid), .o_col_bot(col_bot),
    .o_col_valid(col_valid)
  );

  window_regs u_window_regs (
    .clk(clk), .rst_n(rst_n),
    .i_col_top(col_top), .i_col_mid(col_mid), .i_col_bot(col_bot),
    .i_col_valid(col_valid),
    .o_tap0(tap0), .o_tap1(tap1), .o_tap2(tap2),
    .o_tap3(tap3), .o_tap4(tap4), .o_tap5(tap5),
    .o_tap6(tap6), .o_tap7(tap7), .o_tap8(tap8)
  );

  filter_ctrl u_filter_ctrl (
    .clk(clk), .rst_n(rst_n),
    .i_pixel_valid(i_pixel_valid), .i_frame_start(i_frame_start),
    .o_win_valid(win_valid), .o_row_first(row_first), .o_frame_done(o_frame_done)
  );

  window_sum u_window_sum (
    .clk(clk), .rst_n(rst_n),
    .i_tap0(tap0), .i_tap1(tap1), .i_tap2(tap2),
    .i_tap3(tap3), .i_tap4(tap4), .i_tap5(tap5),
    .i_tap6(tap6), .i_tap7(tap7), .i_tap8(tap8),
    .i_win_valid(win_valid), .i_row_first(row_first),
    .o_run_sum(run_sum), .o_centre(centre), .o_run_valid(run_valid)
  );

  threshold_unit u_threshold_unit (
    .clk(clk), .rst_n(rst_n),
    .i_run_sum(run_sum), .i_centre(centre), .i_run_valid(run_valid),
    .o_bin(o_bin), .o_bin_valid(o_bin_valid)
  );

endmodule

`default_nettype wire

//--- tests/box_threshold_tb.sv
`default_nettype none

module box_threshold_tb
  import box_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_FRAMES = 4;
  localparam int LATENCY = 8;
  localparam int OUT_PER_FRAME = (COLS - 2) * (ROWS - 2);
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * COLS * ROWS * 4 + 200;

  logic             clk = 1'b0;
  logic             rst_n;
  logic [PIX_W-1:0] i_pixel;
  logic             i_pixel_valid;
  logic             i_frame_start;
  logic             o_bin;
  logic             o_bin_valid;
  logic             o_frame_done;

  int    seed = 97;
  string test_name = "reset";
  int    drive_row = 0;
  int    drive_col = 0;
  int    hot_row = -1;
  int    hot_col = -1;
  int    exp_ones = 0;
  int    bin_cnt = 0;
  int    ones_cnt = 0;
  int    done_cnt = 0;

  logic [LATENCY-1:0] win_pipe = '0;
  logic [LATENCY-1:0] exp_pipe = '0;
  logic [1:0]         rst_hist = '0;
  logic               completes;
  logic               exp_now;

  box_threshold_top DUT (
    .clk(clk), .rst_n(rst_n),
    .i_pixel(i_pixel), .i_pixel_valid(i_pixel_valid), .i_frame_start(i_frame_start),
    .o_bin(o_bin), .o_bin_valid(o_bin_valid), .o_frame_done(o_frame_done)
  );

  always #10 clk = ~clk;

  // A strobe completes the window centred one row up and one column left.
  assign completes = i_pixel_valid && drive_row >= 2 && drive_col >= 2;
  assign exp_now   = completes && drive_row - 1 == hot_row && drive_col - 1 == hot_col;

  always @(posedge clk) begin
    win_pipe <= {win_pipe[LATENCY-2:0], completes};
    exp_pipe <= {exp_pipe[LATENCY-2:0], exp_now};
    rst_hist <= {rst_hist[0], !rst_n};
    if (o_frame_done) begin
      bin_cnt  <= 0;
      ones_cnt <= 0;
      done_cnt <= done_cnt + 1;
    end else if (o_bin_valid) begin
      bin_cnt  <= bin_cnt + 1;
      ones_cnt <= ones_cnt + (o_bin ? 1 : 0);
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  // Reset and the cycle after it keep the outputs quiet.
  quiet_in_reset: assert property (
    @(posedge clk) |rst_hist |-> !o_bin_valid && !o_frame_done
  ) else report_failure("Outputs were active during or just after reset");

  latency_ok: assert property (
    @(posedge clk) disable iff (!rst_n) o_bin_valid == win_pipe[LATENCY-1]
  ) else report_failure($sformatf("CHECK FAILED %s: o_bin_valid expected %0b actual %0b",
    test_name, $sampled(win_pipe[LATENCY-1]), $sampled(o_bin_valid)));

  bin_value_ok: assert property (
    @(posedge clk) disable iff (!rst_n) o_bin_valid |-> o_bin == exp_pipe[LATENCY-1]
  ) else report_failure($sformatf("CHECK FAILED %s: o_bin expected %0b actual %0b",
    test_name, $sampled(exp_pipe[LATENCY-1]), $sampled(o_bin)));

  frame_count_ok: assert property (
    @(posedge clk) disable iff (!rst_n) o_frame_done |-> bin_cnt == OUT_PER_FRAME
  ) else report_failure($sformatf("CHECK FAILED %s: outputs per frame expected %0d actual %0d",
    test_name, OUT_PER_FRAME, $sampled(bin_cnt)));

  frame_ones_ok: assert property (
    @(posedge clk) disable iff (!rst_n) o_frame_done |-> ones_cnt == exp_ones
  ) else report_failure($sformatf("CHECK FAILED %s: foreground count expected %0d actual %0d",
    test_name, $sampled(exp_ones), $sampled(ones_cnt)));

  done_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) o_frame_done |=> !o_frame_done
  ) else report_failure("o_frame_done stayed high for more than one cycle");

  // Sends one frame, optionally with random idle cycles, then waits for done.
  task automatic send_frame(input string name, input int base, input int hot_r,
                            input int hot_c, input bit gaps);
    int gap;
    int target;
    test_name = name;
    hot_row   = hot_r;
    hot_col   = hot_c;
    exp_ones  = (hot_r >= 0) ? 1 : 0;
    target    = done_cnt + 1;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        gap = gaps ? ($random(seed) & 3) : 0;
        repeat (gap) begin
          i_pixel_valid = 1'b0;
          i_frame_start = 1'b0;
          @(posedge clk);
          #2;
        end
        i_pixel       = (r == hot_r && c == hot_c) ? 8'd255 : PIX_W'(base);
        i_pixel_valid = 1'b1;
        i_frame_start = (r == 0 && c == 0);
        drive_row     = r;
        drive_col     = c;
        @(posedge clk);
        #2;
      end
    end
    i_pixel_valid = 1'b0;
    i_frame_start = 1'b0;
    wait (done_cnt == target);
    @(posedge clk);
    #2;
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_failure("Watchdog expired before all frames were processed");
  end

  initial begin
    rst_n         = 1'b0;
    i_pixel       = '0;
    i_pixel_valid = 1'b0;
    i_frame_start = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    send_frame("constant_frame", 100, -1, -1, 1'b0);
    send_frame("single_hot_pixel", 0, 3, 6, 1'b0);
    send_frame("constant_frame_gaps", 100, -1, -1, 1'b1);
    send_frame("single_hot_pixel_gaps", 0, 5, 11, 1'b1);
    // Idle tail catches stray outputs after the last frame.
    repeat (20) @(posedge clk);
    if (done_cnt != NUM_FRAMES) begin
      report_failure($sformatf("CHECK FAILED frame_done_total: expected %0d actual %0d",
        NUM_FRAMES, done_cnt));
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sim.f
common/box_pkg.sv
line_buffer/line_buffer.sv
line_buffer/window_regs.sv
window_sum/window_sum.sv
verilog/filter_ctrl.sv
verilog/threshold_unit.sv
verilog/box_threshold_top.sv
tests/box_threshold_tb.sv
